// ==== vlog.f ====
lcd_video_pkg.sv
frame_store.sv
video_timing.sv
shade_blend.sv
color_mix.sv
lcd_video_top.sv
tb_lcd_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run, succeeds only if the testbench reports success
verilator --binary --assert -j 0 --top-module tb_lcd_video -f vlog.f -o sim_lcd_video \
    && ./obj_dir/sim_lcd_video | tee /dev/stderr | grep -q "Everything OK" \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

// ==== tb_lcd_video.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for lcd_video_top with lcd images from a seeded lfsr
// expected colours are built from the package shading helpers
// stops at the first mismatch and the watchdog allows six video frames
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_video;
    import lcd_video_pkg::*;

    localparam int     CLK_PERIOD  = 10;
    localparam longint WATCHDOG_NS = longint'(6) * H_TOTAL * V_TOTAL * PIXEL_DIV * CLK_PERIOD;

    logic        clk_sys;
    logic        reset;
    logic        frame_complete;
    contrast_t   lcd_contrast;
    logic [7:0]  lcd_read_column = 8'h00;
    logic        blend_enable;
    logic [7:0]  lcd_read_x;
    logic [3:0]  lcd_read_y;
    logic        pixel_ce;
    logic        hs;
    logic        vs;
    logic        de;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;

    logic [31:0] lfsr;
    logic [7:0]  lcd_img [FB_DEPTH];            // what the lcd controller shows
    logic [7:0]  cap_img [FB_BANKS][FB_DEPTH];  // captured copies in slot count mod 4
    contrast_t   cap_con [FB_BANKS];
    int          cap_cnt;

    // raster monitor state
    int          cycles = 0;
    logic        seen_ce = 1'b0;
    logic        vs_q = 1'b0;
    logic        hs_q = 1'b0;
    logic        de_q = 1'b0;
    int          frame_pix = 0;
    int          vs_pix = 0;
    int          hs_pix = 0;
    int          de_cnt = 0;
    int          de_lines = 0;
    int          vs_rises = 0;
    int          cur_mode = 0;                  // 0 idle, 1 single, 2 blend
    int          want_mode = 0;
    int          frames_checked = 0;

    lcd_video_top uut
    (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .frame_complete  (frame_complete),
        .lcd_contrast    (lcd_contrast),
        .lcd_read_column (lcd_read_column),
        .blend_enable    (blend_enable),
        .lcd_read_x      (lcd_read_x),
        .lcd_read_y      (lcd_read_y),
        .pixel_ce        (pixel_ce),
        .hs              (hs),
        .vs              (vs),
        .de              (de),
        .red             (red),
        .green           (green),
        .blue            (blue)
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // lcd controller model answers the addressed column byte
    always @(posedge clk_sys)
        lcd_read_column <= lcd_img[int'(lcd_read_y) * LCD_W + int'(lcd_read_x)];

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else
            stop_with_failure($sformatf("CHECK FAILED %s: got 0x%02h, expected 0x%02h",
                                        name, got, exp));
    endtask

    task automatic verify_count(input string name, input int got, input int exp);
        assert (got == exp)
        else
            stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                        name, got, exp));
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_step(lfsr);             // one step per bit
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    task automatic fill_lcd();
        for (int i = 0; i < FB_DEPTH; i++)
            lcd_img[i] = random_byte();
    endtask

    // intensity at image pixel (x, y) from the newest bank alone or the mean of four
    function automatic int expected_level(input int x, input int y, input int mode);
        int sum;
        int slot;
        int addr;
        sum  = 0;
        addr = (y / 8) * LCD_W + x;
        for (int k = 0; k < FB_BANKS; k++)
        begin
            slot = (cap_cnt - 1 - k) & (FB_BANKS - 1);
            sum  = sum + int'(pixel_intensity(cap_img[slot][addr][y % 8], cap_con[slot]));
            if (mode == 1)
                return sum;
        end
        return sum / FB_BANKS;
    endfunction

    task automatic inspect_pixel(input int x, input int y);
        logic [7:0] level;
        level = 8'(expected_level(x, y, cur_mode));
        compare_byte($sformatf("red at (%0d,%0d)", x, y), red, tint_channel(level, 0));
        compare_byte($sformatf("green at (%0d,%0d)", x, y), green, tint_channel(level, 1));
        compare_byte($sformatf("blue at (%0d,%0d)", x, y), blue, tint_channel(level, 2));
    endtask

    // pulse frame_complete (again mid capture if asked) and wait for the walker to wrap
    task automatic capture_frame(input contrast_t level, input logic second_pulse);
        int slot;
        lcd_contrast   <= level;
        frame_complete <= 1'b1;
        @(posedge clk_sys);
        frame_complete <= 1'b0;
        if (second_pulse)
        begin
            while (lcd_read_y != 4'd3)
                @(posedge clk_sys);
            frame_complete <= 1'b1;
            @(posedge clk_sys);
            frame_complete <= 1'b0;
        end
        while (lcd_read_y != 4'(LCD_ROWS - 1))
            @(posedge clk_sys);
        while (lcd_read_y != 4'd0)
            @(posedge clk_sys);
        slot = cap_cnt % FB_BANKS;
        for (int i = 0; i < FB_DEPTH; i++)
            cap_img[slot][i] = lcd_img[i];
        cap_con[slot] = level;
        cap_cnt++;
    endtask

    task automatic show_frame(input int mode);
        int target;
        target    = frames_checked + 1;
        want_mode = mode;                       // taken up at the next vs rise
        wait (frames_checked == target);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor sampling the values of the cycle before each edge

    always @(posedge clk_sys)
    begin
        cycles++;
        if (cycles > 1)
        begin
            if (!de)
            begin
                compare_byte("red while blanked", red, 8'h00);
                compare_byte("green while blanked", green, 8'h00);
                compare_byte("blue while blanked", blue, 8'h00);
            end
            if (!seen_ce && !pixel_ce)
            begin
                compare_byte("de after reset", 8'(de), 8'h00);
                compare_byte("hs after reset", 8'(hs), 8'h00);
                compare_byte("vs after reset", 8'(vs), 8'h00);
            end
        end

        if (pixel_ce)
        begin
            seen_ce = 1'b1;
            if (vs && !vs_q)
            begin
                if (vs_rises > 0)
                begin
                    verify_count("pixel_ce per frame", frame_pix, H_TOTAL * V_TOTAL);
                    verify_count("de lines per frame", de_lines, LCD_H);
                end
                vs_rises++;
                frame_pix = 0;
                de_lines  = 0;
                cur_mode  = want_mode;
                want_mode = 0;
            end
            frame_pix++;

            if (vs)
                vs_pix++;
            else if (vs_q)
            begin
                verify_count("vs width in pixels", vs_pix, 3 * H_TOTAL);
                vs_pix = 0;
            end

            if (hs)
                hs_pix++;
            else if (hs_q)
            begin
                verify_count("hs width in pixels", hs_pix, HS_WIDTH);
                hs_pix = 0;
            end

            if (de)
            begin
                if (cur_mode != 0)
                    inspect_pixel(de_cnt, de_lines);
                de_cnt++;
            end
            else if (de_q)
            begin
                verify_count("de pixels per line", de_cnt, LCD_W);
                de_cnt = 0;
                de_lines++;
                if (cur_mode != 0 && de_lines == LCD_H)
                begin
                    cur_mode = 0;
                    frames_checked++;
                end
            end

            vs_q = vs;
            hs_q = hs;
            de_q = de;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial
    begin
        clk_sys        = 1'b0;
        reset          = 1'b1;
        frame_complete = 1'b0;
        lcd_contrast   = '0;
        blend_enable   = 1'b0;
        lfsr           = 32'd77867;
        cap_cnt        = 0;
        fill_lcd();
        repeat (3) @(posedge clk_sys);
        reset <= 1'b0;
        @(posedge clk_sys);

        // single frame with a stray pulse mid capture
        capture_frame(6'd35, 1'b1);
        fill_lcd();                             // a re-armed capture would show this
        show_frame(1);

        // fill all four banks and blend them
        capture_frame(6'd20, 1'b0);
        fill_lcd();
        capture_frame(6'd28, 1'b0);
        fill_lcd();
        capture_frame(6'd50, 1'b0);
        blend_enable <= 1'b1;
        show_frame(2);

        $display("Everything OK");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        stop_with_failure("timeout, the video frames never completed");
    end

endmodule

`default_nettype wire

// ==== lcd_video_top.sv ====
////////////////////////////////////////////////////////////////////////////
// lcd capture to rgb video, outputs lag the raster by 2 clk_sys
// frame_complete is a one cycle pulse from the lcd controller
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcd_video_top
(
    input  wire logic                      clk_sys,
    input  wire logic                      reset,
    input  wire logic                      frame_complete,
    input  wire lcd_video_pkg::contrast_t  lcd_contrast,
    input  wire logic [7:0]                lcd_read_column,
    input  wire logic                      blend_enable,
    output logic [7:0]                     lcd_read_x,
    output logic [3:0]                     lcd_read_y,
    output logic                           pixel_ce,
    output logic                           hs,
    output logic                           vs,
    output logic                           de,
    output logic [7:0]                     red,
    output logic [7:0]                     green,
    output logic [7:0]                     blue
);
    import lcd_video_pkg::*;

    logic                           pix_en;
    logic                           vt_hs;
    logic                           vt_vs;
    logic                           vt_active;
    logic [2:0]                     row_bit;
    fb_addr_t                       rd_addr;
    logic [FB_BANKS-1:0][7:0]       bank_bytes;
    contrast_t [FB_BANKS-1:0]       bank_contrast;
    intensity_t                     intensity;

    video_timing u_timing
    (
        .clk_sys (clk_sys),
        .reset   (reset),
        .pix_en  (pix_en),
        .hs      (vt_hs),
        .vs      (vt_vs),
        .active  (vt_active),
        .row_bit (row_bit),
        .rd_addr (rd_addr)
    );

    frame_store u_store
    (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .frame_complete  (frame_complete),
        .lcd_contrast    (lcd_contrast),
        .lcd_read_column (lcd_read_column),
        .rd_addr         (rd_addr),
        .lcd_read_x      (lcd_read_x),
        .lcd_read_y      (lcd_read_y),
        .bank_bytes      (bank_bytes),
        .bank_contrast   (bank_contrast)
    );

    shade_blend u_shade
    (
        .clk_sys       (clk_sys),
        .row_bit       (row_bit),
        .bank_bytes    (bank_bytes),
        .bank_contrast (bank_contrast),
        .blend_enable  (blend_enable),
        .intensity     (intensity)
    );

    color_mix u_color
    (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .pix_en    (pix_en),
        .hs_in     (vt_hs),
        .vs_in     (vt_vs),
        .active_in (vt_active),
        .intensity (intensity),
        .pixel_ce  (pixel_ce),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// ==== color_mix.sv ====
////////////////////////////////////////////////////////////////////////////
// tints the intensity into rgb, black outside the active window
// syncs and enables are delayed two cycles to meet the registered colour
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module color_mix
(
    input  wire logic                       clk_sys,
    input  wire logic                       reset,
    input  wire logic                       pix_en,
    input  wire logic                       hs_in,
    input  wire logic                       vs_in,
    input  wire logic                       active_in,
    input  wire lcd_video_pkg::intensity_t  intensity,
    output logic                            pixel_ce,
    output logic                            hs,
    output logic                            vs,
    output logic                            de,
    output logic [7:0]                      red,
    output logic [7:0]                      green,
    output logic [7:0]                      blue
);
    import lcd_video_pkg::*;

    logic [3:0] ctl_d1;     // {ce, hs, vs, de} stage one
    logic [3:0] ctl_d2;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            ctl_d1 <= '0;
            ctl_d2 <= '0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end
        else
        begin
            ctl_d1 <= {pix_en, hs_in, vs_in, active_in};
            ctl_d2 <= ctl_d1;
            red    <= ctl_d1[0] ? tint_channel(intensity, 0) : 8'd0;
            green  <= ctl_d1[0] ? tint_channel(intensity, 1) : 8'd0;
            blue   <= ctl_d1[0] ? tint_channel(intensity, 2) : 8'd0;
        end
    end

    assign {pixel_ce, hs, vs, de} = ctl_d2;

endmodule

`default_nettype wire

// ==== shade_blend.sv ====
////////////////////////////////////////////////////////////////////////////
// bit select and contrast lookup on the registered bank bytes
// blend averages the four newest frames, five shades in all
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shade_blend
(
    input  wire logic                                         clk_sys,
    input  wire logic [2:0]                                   row_bit,
    input  wire logic [lcd_video_pkg::FB_BANKS-1:0][7:0]      bank_bytes,
    input  wire lcd_video_pkg::contrast_t [lcd_video_pkg::FB_BANKS-1:0] bank_contrast,
    input  wire logic                                         blend_enable,
    output lcd_video_pkg::intensity_t                         intensity
);
    import lcd_video_pkg::*;

    logic [2:0] row_bit_q;              // lines up with the ram read
    intensity_t level [FB_BANKS];
    logic [9:0] level_sum;

    always_ff @(posedge clk_sys)
    begin
        row_bit_q <= row_bit;
    end

    always_comb
    begin
        level_sum = '0;
        for (int i = 0; i < FB_BANKS; i++)
        begin
            level[i]  = pixel_intensity(bank_bytes[i][row_bit_q], bank_contrast[i]);
            level_sum = level_sum + 10'(level[i]);
        end
    end

    // newest frame alone, or mean of all four
    assign intensity = blend_enable ? level_sum[9:2] : level[0];

endmodule

`default_nettype wire

// ==== video_timing.sv ====
////////////////////////////////////////////////////////////////////////////
// 407x262 raster, one pixel enable every 5 clk_sys
// all outputs update together, pix_en is high in the cycle they change
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_timing
(
    input  wire logic                clk_sys,
    input  wire logic                reset,
    output logic                     pix_en,
    output logic                     hs,
    output logic                     vs,
    output logic                     active,
    output logic [2:0]               row_bit,
    output lcd_video_pkg::fb_addr_t  rd_addr
);
    import lcd_video_pkg::*;

    logic [2:0] div_cnt;
    logic       tick;               // internal pixel enable
    logic [8:0] h_cnt;
    logic [8:0] v_cnt;
    logic       h_in;
    logic       v_in;
    logic       hs_win;
    logic [6:0] img_x;              // 0..95
    logic [5:0] img_y;              // 0..63

    assign tick   = (div_cnt == 3'(PIXEL_DIV - 1));
    assign h_in   = (h_cnt >= 9'(H_START)) && (h_cnt < 9'(H_START + LCD_W));
    assign v_in   = (v_cnt >= 9'(V_START)) && (v_cnt < 9'(V_START + LCD_H));
    assign hs_win = (h_cnt >= 9'(HS_START)) && (h_cnt < 9'(HS_START + HS_WIDTH));

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            div_cnt <= '0;
        else
            div_cnt <= tick ? 3'd0 : div_cnt + 3'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // raster counters and registered video outputs

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pix_en <= 1'b0;
            h_cnt  <= '0;
            v_cnt  <= '0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            active <= 1'b0;
            img_x  <= '0;
            img_y  <= '0;
        end
        else
        begin
            pix_en <= tick;
            if (tick)
            begin
                h_cnt <= h_cnt + 9'd1;
                if (h_cnt == 9'(H_TOTAL - 1))
                begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == 9'(V_TOTAL - 1)) ? 9'd0 : v_cnt + 9'd1;
                end

                hs <= hs_win;
                if (h_cnt == 9'(HS_START))
                begin
                    if (v_cnt == 9'(VS_FIRST))
                        vs <= 1'b1;
                    if (v_cnt == 9'(VS_LAST))
                        vs <= 1'b0;
                end

                active <= h_in && v_in;

                // image walker, steps after each active pixel
                if (!v_in)
                begin
                    img_x <= '0;
                    img_y <= '0;
                end
                else if (active)
                begin
                    img_x <= img_x + 7'd1;
                    if (img_x == 7'(LCD_W - 1))
                    begin
                        img_x <= '0;
                        img_y <= (img_y == 6'(LCD_H - 1)) ? 6'd0 : img_y + 6'd1;
                    end
                end
            end
        end
    end

    assign row_bit = img_y[2:0];
    assign rd_addr = fb_addr_t'(img_y[5:3]) * fb_addr_t'(LCD_W) + fb_addr_t'(img_x);

endmodule

`default_nettype wire

// ==== frame_store.sv ====
////////////////////////////////////////////////////////////////////////////
// captures the lcd column by column into four rotating banks
// one step per 8 clk_sys, lcd_read_column must be valid while x/y are held
// read data is registered, banks come out newest first
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_store
(
    input  wire logic                                       clk_sys,
    input  wire logic                                       reset,
    input  wire logic                                       frame_complete,
    input  wire lcd_video_pkg::contrast_t                   lcd_contrast,
    input  wire logic [7:0]                                 lcd_read_column,
    input  wire lcd_video_pkg::fb_addr_t                    rd_addr,
    output logic [7:0]                                      lcd_read_x,
    output logic [3:0]                                      lcd_read_y,
    output logic [lcd_video_pkg::FB_BANKS-1:0][7:0]         bank_bytes,
    output lcd_video_pkg::contrast_t [lcd_video_pkg::FB_BANKS-1:0] bank_contrast
);
    import lcd_video_pkg::*;

    logic       armed;                  // capture pending or running
    logic [2:0] step_cnt;
    logic       step;
    bank_idx_t  wr_idx;
    bank_idx_t  rd_idx;                 // newest complete frame
    fb_addr_t   wr_addr;

    logic [7:0] rd_q [FB_BANKS];
    contrast_t  contrast_q [FB_BANKS];

    assign step    = armed && (step_cnt == 3'(LCD_STEP_DIV - 1));
    assign wr_addr = fb_addr_t'(lcd_read_y) * fb_addr_t'(LCD_W) + fb_addr_t'(lcd_read_x);

    ////////////////////////////////////////////////////////////////////////////
    // capture sequencer

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            armed      <= 1'b0;
            step_cnt   <= '0;
            wr_idx     <= 2'd1;
            rd_idx     <= 2'd0;
            lcd_read_x <= '0;
            lcd_read_y <= '0;
        end
        else
        begin
            step_cnt <= (step_cnt == 3'(LCD_STEP_DIV - 1)) ? 3'd0 : step_cnt + 3'd1;

            if (frame_complete)
                armed <= 1'b1;          // no effect while already armed

            if (step)
            begin
                if (lcd_read_x == 8'(LCD_W - 1))
                begin
                    lcd_read_x <= '0;
                    if (lcd_read_y == 4'(LCD_ROWS - 1))
                    begin
                        // last byte, publish the bank
                        lcd_read_y <= '0;
                        rd_idx     <= wr_idx;
                        wr_idx     <= wr_idx + 2'd1;
                        armed      <= 1'b0;
                    end
                    else
                        lcd_read_y <= lcd_read_y + 4'd1;
                end
                else
                    lcd_read_x <= lcd_read_x + 8'd1;
            end
        end
    end

    // one ram per bank, contrast latched with every write
    for (genvar b = 0; b < FB_BANKS; b++)
    begin : g_bank
        logic [7:0] mem [FB_DEPTH];

        always_ff @(posedge clk_sys)
        begin
            if (step && wr_idx == bank_idx_t'(b))
            begin
                mem[wr_addr]  <= lcd_read_column;
                contrast_q[b] <= lcd_contrast;
            end
            rd_q[b] <= mem[rd_addr];
        end
    end

    // rotate so index 0 is the newest bank
    always_comb
    begin
        bank_idx_t sel;
        for (int i = 0; i < FB_BANKS; i++)
        begin
            sel              = rd_idx - bank_idx_t'(i);
            bank_bytes[i]    = rd_q[sel];
            bank_contrast[i] = contrast_q[sel];
        end
    end

endmodule

`default_nettype wire

// ==== lcd_video_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// geometry, contrast table and tints for the 96x64 handheld LCD path
// contrast values are pairs of (light, dark) intensity per 6-bit setting
// tint mixing divides by 255, so intensity 255 gives the pure on tint
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package lcd_video_pkg;

    // lcd image
    localparam int LCD_W    = 96;
    localparam int LCD_H    = 64;
    localparam int LCD_ROWS = LCD_H / 8;        // one byte per 8 pixel rows
    localparam int FB_DEPTH = LCD_W * LCD_ROWS;
    localparam int FB_BANKS = 4;

    // raster, counted in pixel enables
    localparam int H_TOTAL  = 407;
    localparam int V_TOTAL  = 262;
    localparam int H_START  = (H_TOTAL - LCD_W) / 2;
    localparam int V_START  = (V_TOTAL - LCD_H) / 2;
    localparam int HS_START = 383;
    localparam int HS_WIDTH = 24;
    localparam int VS_FIRST = 1;                // lines are sampled at HS_START
    localparam int VS_LAST  = 4;

    localparam int PIXEL_DIV    = 5;
    localparam int LCD_STEP_DIV = 8;            // emulated cpu clock enable

    typedef logic [9:0] fb_addr_t;
    typedef logic [1:0] bank_idx_t;
    typedef logic [5:0] contrast_t;
    typedef logic [7:0] intensity_t;

    ////////////////////////////////////////////////////////////////////////////
    // contrast table, index is {contrast, pixel bit}

    localparam logic [7:0] CONTRAST_LEVELS [128] = '{
          8'd0,   8'd4,   8'd0,   8'd4,   8'd0,   8'd4,   8'd0,   8'd4,
          8'd0,   8'd6,   8'd0,  8'd11,   8'd0,  8'd17,   8'd0,  8'd24,
          8'd0,  8'd31,   8'd0,  8'd40,   8'd0,  8'd48,   8'd0,  8'd57,
          8'd0,  8'd67,   8'd0,  8'd77,   8'd0,  8'd88,   8'd0,  8'd99,
          8'd0, 8'd110,   8'd0, 8'd122,   8'd0, 8'd133,   8'd0, 8'd146,
          8'd0, 8'd158,   8'd0, 8'd171,   8'd0, 8'd184,   8'd0, 8'd198,
          8'd0, 8'd212,   8'd0, 8'd226,   8'd0, 8'd240,   8'd0, 8'd255,
          8'd2, 8'd255,   8'd5, 8'd255,  8'd10, 8'd255,  8'd15, 8'd255,
         8'd21, 8'd255,  8'd27, 8'd255,  8'd34, 8'd255,  8'd41, 8'd255,
         8'd48, 8'd255,  8'd56, 8'd255,  8'd64, 8'd255,  8'd73, 8'd255,
         8'd81, 8'd255,  8'd90, 8'd255, 8'd100, 8'd255, 8'd109, 8'd255,
        8'd119, 8'd255, 8'd129, 8'd255, 8'd139, 8'd255, 8'd149, 8'd255,
        8'd160, 8'd255, 8'd171, 8'd255, 8'd182, 8'd255, 8'd193, 8'd255,
        8'd204, 8'd255, 8'd216, 8'd255, 8'd228, 8'd255, 8'd240, 8'd255,
        8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255,
        8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255
    };

    // lcd tints as r, g, b
    localparam logic [7:0] OFF_TINT [3] = '{8'hB7, 8'hCA, 8'hB7};
    localparam logic [7:0] ON_TINT  [3] = '{8'h04, 8'h16, 8'h04};

    ////////////////////////////////////////////////////////////////////////////
    // shading helpers

    function automatic intensity_t pixel_intensity(input logic px, input contrast_t contrast);
        return CONTRAST_LEVELS[{contrast, px}];
    endfunction

    // ch 0 red, 1 green, 2 blue
    function automatic logic [7:0] tint_channel(input intensity_t level, input int ch);
        logic [15:0] mix;
        mix = 16'(8'hFF - level) * 16'(OFF_TINT[ch]) + 16'(level) * 16'(ON_TINT[ch]);
        return 8'(mix / 16'd255);   // max is 255*255, fits
    endfunction

endpackage

`default_nettype wire
